// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
   input  logic                 clk,
   input  logic                 reset,

   input  rob_pkg::t_retire_wr  retire_wr,

   input  rob_pkg::t_reg_addr   src_addr [rob_pkg::NUM_SOURCES],
   output rob_pkg::t_reg_data   src_data [rob_pkg::NUM_SOURCES]
);
   import rob_pkg::*;

   t_reg_data regs [NUM_REGS];

   // Architectural state, updated only at retire
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (retire_wr.wren && (retire_wr.wraddr != '0)) begin
         regs[retire_wr.wraddr] <= retire_wr.wrdata;
      end
   end

   always_comb begin
      for (int s = 0; s < NUM_SOURCES; s++) begin
         if (src_addr[s] == '0) begin
            src_data[s] = '0;            // x0 reads zero
         end else begin
            src_data[s] = regs[src_addr[s]];
         end
      end
   end

endmodule

// File: logic/rob.sv
`timescale 1ns/1ns

module rob (
   input  logic                  clk,
   input  logic                  reset,

   input  rob_pkg::t_uinstr      uinstr,
   output rob_pkg::t_rob_id      next_robid,
   output logic                  rob_full,

   input  logic                  ro_valid,
   input  rob_pkg::t_rob_result  ro_result,

   input  rob_pkg::t_reg_addr    src_addr    [rob_pkg::NUM_SOURCES],
   output logic                  src_pending [rob_pkg::NUM_SOURCES],
   output rob_pkg::t_rob_id      src_robid   [rob_pkg::NUM_SOURCES],

   output rob_pkg::t_retire_wr   retire_wr,
   output logic                  br_mispred,
   output rob_pkg::t_reg_data    br_tgt
);
   import rob_pkg::*;

   t_rob_id                head_id;   // Oldest entry when not empty
   t_rob_id                tail_id;   // Next slot to fill when not full
   t_rob_ent               ents [RB_NUM_ENTS];
   t_rob_ent               head_ent;

   logic                   rob_empty;
   logic                   do_alloc;
   logic                   do_retire;
   logic                   flush_now;
   logic [RB_NUM_ENTS-1:0] alloc_oh;
   logic [RB_NUM_ENTS-1:0] retire_oh;

   assign rob_empty  = (head_id == tail_id);
   assign rob_full   = (head_id.idx == tail_id.idx) && (head_id.wrap != tail_id.wrap);
   assign next_robid = tail_id;

   assign head_ent  = ents[head_id.idx];
   assign do_retire = !rob_empty && (head_ent.state == ENT_DONE);
   assign flush_now = do_retire && head_ent.flush_needed;

   // Dropped when full or when younger entries are being flushed
   assign do_alloc = uinstr.valid && !rob_full && !flush_now;

   assign alloc_oh  = do_alloc  ? (RB_NUM_ENTS'(1) << tail_id.idx) : '0;
   assign retire_oh = do_retire ? (RB_NUM_ENTS'(1) << head_id.idx) : '0;

   always_ff @(posedge clk) begin
      if (reset) begin
         head_id <= '0;
         tail_id <= '0;
      end else if (flush_now) begin
         // Everything younger than the branch is gone
         head_id <= f_incr_robid(head_id);
         tail_id <= f_incr_robid(head_id);
      end else begin
         if (do_retire) begin
            head_id <= f_incr_robid(head_id);
         end
         if (do_alloc) begin
            tail_id <= f_incr_robid(tail_id);
         end
      end
   end

   // Retire write and branch redirect straight from the head slot
   always_comb begin
      retire_wr.wren   = do_retire && (head_ent.uinstr.dst_type == OP_REG)
                       && (head_ent.uinstr.dst_reg != '0);
      retire_wr.wraddr = head_ent.uinstr.dst_reg;
      retire_wr.wrdata = head_ent.data;
   end

   assign br_mispred = flush_now;
   assign br_tgt     = head_ent.data;

   for (genvar i = 0; i < RB_NUM_ENTS; i++) begin : g_ents
      rob_entry u_rob_entry (
         .clk          (clk),
         .reset        (reset),
         .alloc        (alloc_oh[i]),
         .alloc_uinstr (uinstr),
         .ro_valid     (ro_valid),
         .ro_result    (ro_result),
         .robid_idx    (RB_IDX_W'(i)),
         .flush        (flush_now),
         .retire       (retire_oh[i]),
         .ent          (ents[i])
      );
   end

   rob_src_lookup u_rob_src_lookup (
      .ents        (ents),
      .head_id     (head_id),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid)
   );

endmodule

// File: logic/rob_core.sv
`timescale 1ns/1ns

module rob_core (
   input  logic                  clk,
   input  logic                  reset,

   input  rob_pkg::t_uinstr      uinstr,
   output rob_pkg::t_rob_id      next_robid,
   output logic                  rob_full,

   input  logic                  ro_valid,
   input  rob_pkg::t_rob_result  ro_result,

   input  rob_pkg::t_reg_addr    src_addr    [rob_pkg::NUM_SOURCES],
   output logic                  src_pending [rob_pkg::NUM_SOURCES],
   output rob_pkg::t_rob_id      src_robid   [rob_pkg::NUM_SOURCES],
   output rob_pkg::t_reg_data    src_data    [rob_pkg::NUM_SOURCES],

   output rob_pkg::t_retire_wr   retire_wr,
   output logic                  br_mispred,
   output rob_pkg::t_reg_data    br_tgt
);

   rob u_rob (
      .clk         (clk),
      .reset       (reset),
      .uinstr      (uinstr),
      .next_robid  (next_robid),
      .rob_full    (rob_full),
      .ro_valid    (ro_valid),
      .ro_result   (ro_result),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid),
      .retire_wr   (retire_wr),
      .br_mispred  (br_mispred),
      .br_tgt      (br_tgt)
   );

   // Retire port feeds the register file directly
   reg_file u_reg_file (
      .clk       (clk),
      .reset     (reset),
      .retire_wr (retire_wr),
      .src_addr  (src_addr),
      .src_data  (src_data)
   );

endmodule

// File: logic/rob_entry.sv
`timescale 1ns/1ns

module rob_entry (
   input  logic                          clk,
   input  logic                          reset,

   input  logic                          alloc,
   input  rob_pkg::t_uinstr              alloc_uinstr,

   input  logic                          ro_valid,
   input  rob_pkg::t_rob_result          ro_result,
   input  logic [rob_pkg::RB_IDX_W-1:0]  robid_idx,

   input  logic                          flush,
   input  logic                          retire,

   output rob_pkg::t_rob_ent             ent
);
   import rob_pkg::*;

   t_ent_state state;
   logic       flush_needed;
   t_uinstr    uinstr_q;
   t_reg_data  data_q;
   logic       complete;

   // Result tag hits this slot while it waits
   assign complete = ro_valid && (ro_result.robid.idx == robid_idx) && (state == ENT_WAIT);

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ENT_FREE;
         flush_needed <= 1'b0;
      end else if (flush || retire) begin   // Flush wins over a late completion
         state        <= ENT_FREE;
         flush_needed <= 1'b0;
      end else begin
         case (state)
            ENT_FREE: begin
               if (alloc) begin
                  state <= ENT_WAIT;
               end
            end
            ENT_WAIT: begin
               if (complete) begin
                  state        <= ENT_DONE;
                  flush_needed <= ro_result.mispred;
               end
            end
            default: begin
               state <= state;           // Held until retired or flushed
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         uinstr_q <= alloc_uinstr;
      end
      if (complete) begin
         data_q <= ro_result.data;
      end
   end

   assign ent = '{state: state, uinstr: uinstr_q, data: data_q, flush_needed: flush_needed};

endmodule

// File: logic/rob_pkg.sv
package rob_pkg;

   localparam int RB_NUM_ENTS = 8;
   localparam int RB_IDX_W    = 3;
   localparam int NUM_SOURCES = 2;
   localparam int NUM_REGS    = 32;

   typedef logic [4:0]  t_reg_addr;
   typedef logic [31:0] t_reg_data;

   // Wrap bit flips each lap around the slots
   typedef struct packed {
      logic                wrap;
      logic [RB_IDX_W-1:0] idx;
   } t_rob_id;

   typedef enum logic {
      OP_NONE,
      OP_REG
   } t_optype;

   typedef enum logic [1:0] {
      UOP_ALU,
      UOP_BRANCH,
      UOP_NOP
   } t_uop;

   typedef struct packed {
      logic        valid;
      t_uop        opcode;
      t_optype     dst_type;
      t_reg_addr   dst_reg;
      logic [31:0] pc;
   } t_uinstr;

   typedef struct packed {
      t_rob_id   robid;
      t_reg_data data;      // Branch target when mispred
      logic      mispred;
   } t_rob_result;

   typedef enum logic [1:0] {
      ENT_FREE,
      ENT_WAIT,
      ENT_DONE
   } t_ent_state;

   typedef struct packed {
      t_ent_state state;
      t_uinstr    uinstr;
      t_reg_data  data;
      logic       flush_needed;
   } t_rob_ent;

   typedef struct packed {
      logic      wren;
      t_reg_addr wraddr;
      t_reg_data wrdata;
   } t_retire_wr;

   // Next id in circular order, toggling wrap past the last slot
   function automatic t_rob_id f_incr_robid(t_rob_id id);
      t_rob_id nxt;
      nxt.idx  = id.idx + 1'b1;
      nxt.wrap = (id.idx == RB_IDX_W'(RB_NUM_ENTS - 1)) ? ~id.wrap : id.wrap;
      return nxt;
   endfunction

endpackage

// File: logic/rob_src_lookup.sv
`timescale 1ns/1ns

module rob_src_lookup (
   input  rob_pkg::t_rob_ent   ents        [rob_pkg::RB_NUM_ENTS],
   input  rob_pkg::t_rob_id    head_id,

   input  rob_pkg::t_reg_addr  src_addr    [rob_pkg::NUM_SOURCES],
   output logic                src_pending [rob_pkg::NUM_SOURCES],
   output rob_pkg::t_rob_id    src_robid   [rob_pkg::NUM_SOURCES]
);
   import rob_pkg::*;

   logic [RB_NUM_ENTS-1:0] match [NUM_SOURCES];

   // In-flight slots that still owe the source register
   always_comb begin
      for (int s = 0; s < NUM_SOURCES; s++) begin
         for (int i = 0; i < RB_NUM_ENTS; i++) begin
            match[s][i] = (ents[i].state != ENT_FREE)
                        && (ents[i].uinstr.dst_type == OP_REG)
                        && (ents[i].uinstr.dst_reg == src_addr[s])
                        && (src_addr[s] != '0);   // x0 has no producer
         end
      end
   end

   // Walk from head toward the tail so the last hit is the youngest
   always_comb begin
      logic [RB_IDX_W-1:0] slot;
      logic [RB_IDX_W-1:0] sel;
      for (int s = 0; s < NUM_SOURCES; s++) begin
         sel = head_id.idx;
         for (int k = 0; k < RB_NUM_ENTS; k++) begin
            slot = head_id.idx + RB_IDX_W'(k);
            if (match[s][slot]) begin
               sel = slot;
            end
         end
         src_pending[s]    = |match[s];
         src_robid[s].idx  = sel;
         // Below head idx means the tail has lapped into the next wrap
         src_robid[s].wrap = (sel >= head_id.idx) ? head_id.wrap : ~head_id.wrap;
      end
   end

endmodule

// File: rob_core.f
logic/rob_pkg.sv
logic/rob_entry.sv
logic/rob_src_lookup.sv
logic/rob.sv
logic/reg_file.sv
logic/rob_core.sv
verification/rob_props.sv
verification/rob_core_tb.sv

// File: verification/rob_core_tb.sv
`timescale 1ns/1ns

module rob_core_tb;
   import rob_pkg::*;

   localparam int N_RESET        = 8;
   localparam int N_FILL         = 12;
   localparam int N_RANDOM       = 400;
   localparam int N_DIRECTED     = 48;
   localparam int N_DRAIN        = 40;   // Generous bound per drain
   localparam int PLAN_CYCLES    = N_RESET + N_FILL + N_RANDOM + N_DIRECTED + 3 * N_DRAIN;
   localparam int TIMEOUT_CYCLES = 10 * PLAN_CYCLES;

   typedef struct packed {
      t_rob_id   id;
      t_uinstr   uinstr;
      logic      done;
      t_reg_data data;
      logic      mispred;
   } t_model_ent;

   typedef struct packed {
      t_retire_wr                retire_wr;
      logic                      mispred;
      t_reg_data                 tgt;
      t_rob_id                   next_id;
      logic                      full;
      logic [NUM_SOURCES-1:0]    pending;
      t_rob_id [NUM_SOURCES-1:0] prod_id;
   } t_expect;

   logic        clk;
   logic        reset;
   t_uinstr     uinstr;
   t_rob_id     next_robid;
   logic        rob_full;
   logic        ro_valid;
   t_rob_result ro_result;
   t_reg_addr   src_addr    [NUM_SOURCES];
   logic        src_pending [NUM_SOURCES];
   t_rob_id     src_robid   [NUM_SOURCES];
   t_reg_data   src_data    [NUM_SOURCES];
   t_retire_wr  retire_wr;
   logic        br_mispred;
   t_reg_data   br_tgt;

   t_model_ent  rob_q [$];            // Oldest micro-op at the front
   t_reg_data   ref_regs [NUM_REGS];
   t_rob_id     ref_tail;
   logic [31:0] lfsr_state;
   string       test_name;
   int          cycle_count = 0;
   int          retire_count;

   rob_core u_rob_core (
      .clk         (clk),
      .reset       (reset),
      .uinstr      (uinstr),
      .next_robid  (next_robid),
      .rob_full    (rob_full),
      .ro_valid    (ro_valid),
      .ro_result   (ro_result),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid),
      .src_data    (src_data),
      .retire_wr   (retire_wr),
      .br_mispred  (br_mispred),
      .br_tgt      (br_tgt)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      fail_now($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   task automatic fail_now(string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_retire(string what, t_retire_wr exp, t_retire_wr act);
      if (exp.wren !== act.wren || (exp.wren && exp !== act)) begin
         fail_now($sformatf("mismatch %s %s: expected %h actual %h",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_id(string what, t_rob_id exp, t_rob_id act);
      if (exp !== act) begin
         fail_now($sformatf("mismatch %s %s: expected %h actual %h",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_data(string what, t_reg_data exp, t_reg_data act);
      if (exp !== act) begin
         fail_now($sformatf("mismatch %s %s: expected %h actual %h",
                            test_name, what, exp, act));
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      if (exp !== act) begin
         fail_now($sformatf("mismatch %s %s: expected %b actual %b",
                            test_name, what, exp, act));
      end
   endtask

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] val;
      logic        lsb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lsb        = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         val = {val[30:0], lsb};
      end
      return val;
   endfunction

   function automatic t_rob_id id_after(t_rob_id id);
      logic [3:0] v;
      v = id + 4'd1;                   // Idx carry flips the wrap bit
      return v;
   endfunction

   function automatic t_uinstr make_uop(t_uop op, t_optype dt, t_reg_addr rd, logic [31:0] pc);
      t_uinstr u;
      u.valid    = 1'b1;
      u.opcode   = op;
      u.dst_type = dt;
      u.dst_reg  = rd;
      u.pc       = pc;
      return u;
   endfunction

   function automatic t_rob_result make_result(t_rob_id id, t_reg_data d, logic mp);
      t_rob_result r;
      r.robid   = id;
      r.data    = d;
      r.mispred = mp;
      return r;
   endfunction

   // In-order model of what the DUT shows this cycle
   function automatic t_expect expected_outputs();
      t_expect e;
      e = '0;
      if (rob_q.size() > 0 && rob_q[0].done) begin
         e.retire_wr.wren   = (rob_q[0].uinstr.dst_type == OP_REG)
                            && (rob_q[0].uinstr.dst_reg != 5'd0);
         e.retire_wr.wraddr = rob_q[0].uinstr.dst_reg;
         e.retire_wr.wrdata = rob_q[0].data;
         e.mispred          = rob_q[0].mispred;
         e.tgt              = rob_q[0].data;
      end
      e.next_id = ref_tail;
      e.full    = (rob_q.size() == RB_NUM_ENTS);
      for (int s = 0; s < NUM_SOURCES; s++) begin
         for (int i = 0; i < rob_q.size(); i++) begin
            if (src_addr[s] != 5'd0 && rob_q[i].uinstr.dst_type == OP_REG
                && rob_q[i].uinstr.dst_reg == src_addr[s]) begin
               e.pending[s] = 1'b1;
               e.prod_id[s] = rob_q[i].id;   // Later in queue is younger
            end
         end
      end
      return e;
   endfunction

   task automatic update_model(t_expect e);
      t_model_ent ent;
      t_rob_id    head;
      logic       retiring;
      retiring = rob_q.size() > 0 && rob_q[0].done;
      if (ro_valid) begin
         for (int i = 0; i < rob_q.size(); i++) begin
            if (rob_q[i].id.idx == ro_result.robid.idx && !rob_q[i].done) begin
               ent         = rob_q[i];
               ent.done    = 1'b1;
               ent.data    = ro_result.data;
               ent.mispred = ro_result.mispred;
               rob_q[i]    = ent;
            end
         end
      end
      if (retiring) begin
         head = rob_q[0].id;
         if (e.retire_wr.wren) begin
            ref_regs[e.retire_wr.wraddr] = e.retire_wr.wrdata;
         end
         retire_count++;
         void'(rob_q.pop_front());
         if (e.mispred) begin
            rob_q.delete();            // Younger work is squashed
            ref_tail = id_after(head);
         end
      end
      if (uinstr.valid && !e.full && !e.mispred) begin
         ent.id      = ref_tail;
         ent.uinstr  = uinstr;
         ent.done    = 1'b0;
         ent.data    = '0;
         ent.mispred = 1'b0;
         rob_q.push_back(ent);
         ref_tail = id_after(ref_tail);
      end
   endtask

   // Compare mid low phase, then advance the model past the next edge
   initial begin
      t_expect exp;
      forever begin
         @(negedge clk);
         #40;
         if (!reset) begin
            exp = expected_outputs();
            check_retire("retire_wr", exp.retire_wr, retire_wr);
            check_bit("br_mispred", exp.mispred, br_mispred);
            if (exp.mispred) begin
               check_data("br_tgt", exp.tgt, br_tgt);
            end
            check_id("next_robid", exp.next_id, next_robid);
            check_bit("rob_full", exp.full, rob_full);
            for (int s = 0; s < NUM_SOURCES; s++) begin
               check_bit("src_pending", exp.pending[s], src_pending[s]);
               if (exp.pending[s]) begin
                  check_id("src_robid", exp.prod_id[s], src_robid[s]);
               end
               check_data("src_data", ref_regs[src_addr[s]], src_data[s]);
            end
            update_model(exp);
         end
      end
   end

   task automatic apply(t_uinstr u, logic v, t_rob_result r, t_reg_addr a0, t_reg_addr a1);
      uinstr      = u;
      ro_valid    = v;
      ro_result   = r;
      src_addr[0] = a0;
      src_addr[1] = a1;
   endtask

   task automatic random_cycle(logic alloc_en, logic mispred_en);
      t_uinstr     u;
      t_rob_result r;
      logic        v;
      logic [1:0]  code;
      int          waiting [$];
      int          pick;
      @(negedge clk);
      code    = 2'(rand_bits(2));
      u.valid = alloc_en && (code != 2'd0);
      code    = 2'(rand_bits(2));
      case (code)
         2'd1:    u.opcode = UOP_BRANCH;
         2'd2:    u.opcode = UOP_NOP;
         default: u.opcode = UOP_ALU;
      endcase
      u.dst_type = (u.opcode != UOP_NOP && rand_bits(2) != 0) ? OP_REG : OP_NONE;
      u.dst_reg  = t_reg_addr'(rand_bits(3));   // Small range so lookups hit
      u.pc       = rand_bits(32);
      for (int i = 0; i < rob_q.size(); i++) begin
         if (!rob_q[i].done) begin
            waiting.push_back(i);
         end
      end
      r = '0;
      v = 1'b0;
      if (waiting.size() > 0 && rand_bits(1) == 1) begin
         pick      = waiting[rand_bits(3) % waiting.size()];
         v         = 1'b1;
         r.robid   = rob_q[pick].id;
         r.data    = rand_bits(32);
         r.mispred = mispred_en && (rob_q[pick].uinstr.opcode == UOP_BRANCH)
                   && (rand_bits(2) == 0);
      end
      apply(u, v, r, t_reg_addr'(rand_bits(3)), t_reg_addr'(rand_bits(3)));
   endtask

   task automatic drain();
      random_cycle(1'b0, 1'b0);       // Lets the model catch up with the last allocation
      while (rob_q.size() != 0) begin
         random_cycle(1'b0, 1'b0);
      end
   endtask

   initial begin
      t_uinstr     u_idle;
      t_rob_result r_none;
      u_idle       = '0;
      r_none       = '0;
      lfsr_state   = 32'h2f55;
      ref_tail     = '0;
      retire_count = 0;
      rob_q.delete();
      for (int i = 0; i < NUM_REGS; i++) begin
         ref_regs[i] = '0;
      end
      test_name = "reset";
      reset     = 1'b1;
      apply(u_idle, 1'b0, r_none, 5'd0, 5'd0);
      repeat (N_RESET) @(negedge clk);
      reset = 1'b0;

      test_name = "fill";
      for (int i = 0; i < N_FILL; i++) begin
         @(negedge clk);
         apply(make_uop(UOP_ALU, OP_REG, t_reg_addr'(i % 7 + 1), 32'(i * 4)), 1'b0, r_none,
               t_reg_addr'(i % 7 + 1), 5'd0);
      end
      drain();

      test_name = "random";
      repeat (N_RANDOM) random_cycle(1'b1, 1'b1);
      drain();

      test_name = "flush";
      @(negedge clk);
      apply(make_uop(UOP_BRANCH, OP_NONE, 5'd0, 32'h100), 1'b0, r_none, 5'd5, 5'd6);
      @(negedge clk);
      apply(make_uop(UOP_ALU, OP_REG, 5'd5, 32'h104), 1'b0, r_none, 5'd5, 5'd6);
      @(negedge clk);
      apply(make_uop(UOP_ALU, OP_REG, 5'd6, 32'h108), 1'b0, r_none, 5'd5, 5'd6);
      @(negedge clk);
      apply(u_idle, 1'b1, make_result(rob_q[1].id, 32'h55aa, 1'b0), 5'd5, 5'd6);
      @(negedge clk);
      apply(make_uop(UOP_ALU, OP_REG, 5'd7, 32'h10c), 1'b1,
            make_result(rob_q[0].id, 32'h2000, 1'b1), 5'd5, 5'd7);
      @(negedge clk);
      apply(make_uop(UOP_ALU, OP_REG, 5'd7, 32'h110), 1'b0, r_none, 5'd5, 5'd7);  // Flush cycle
      @(negedge clk);
      apply(make_uop(UOP_ALU, OP_REG, 5'd3, 32'h2000), 1'b0, r_none, 5'd3, 5'd6);
      repeat (N_DIRECTED - 8) random_cycle(1'b1, 1'b1);
      drain();

      @(negedge clk);
      apply(u_idle, 1'b0, r_none, 5'd0, 5'd0);
      repeat (2) @(posedge clk);
      if (retire_count == 0) begin
         fail_now("no micro-op retired during the run");
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

// File: verification/rob_props.sv
`timescale 1ns/1ns

module rob_props (
   input logic                 clk,
   input logic                 reset,
   input rob_pkg::t_rob_id     tail_id,
   input logic                 rob_full,
   input logic                 rob_empty,
   input rob_pkg::t_rob_ent    head_ent,
   input rob_pkg::t_uinstr     uinstr,
   input rob_pkg::t_retire_wr  retire_wr,
   input logic                 br_mispred
);
   import rob_pkg::*;

   // Nothing may sit in the head slot once every entry has left
   a_no_retire_empty: assert property (@(posedge clk) disable iff (reset)
      rob_empty |-> (head_ent.state == ENT_FREE))
      else $error("head slot holds an entry while the ROB is empty");

   // A flush may still move the tail while full
   a_tail_hold_full: assert property (@(posedge clk) disable iff (reset)
      (rob_full && uinstr.valid && !br_mispred) |=> $stable(tail_id))
      else $error("tail moved while the ROB was full");

   a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
      retire_wr.wren |-> (retire_wr.wraddr != 5'd0))
      else $error("retire write aimed at register zero");

   a_quiet_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> !retire_wr.wren && !br_mispred)
      else $error("retire or mispredict right after reset");

endmodule

bind rob rob_props u_rob_props (
   .clk        (clk),
   .reset      (reset),
   .tail_id    (tail_id),
   .rob_full   (rob_full),
   .rob_empty  (rob_empty),
   .head_ent   (head_ent),
   .uinstr     (uinstr),
   .retire_wr  (retire_wr),
   .br_mispred (br_mispred)
);
